//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module fpu_unit_tb -Mdir obj_dir
	./obj_dir/Vfpu_unit_tb

clean:
	rm -rf obj_dir

//--- dv/fpu_unit_tb.sv
// Testbench for the scalar floating-point execute unit
// Sends a table of requests under upstream credit control, returns
// downstream credits after random delays and checks each response in order
module fpu_unit_tb import fpu_pkg::*; ();

	localparam int IN_DEPTH    = 4;
	localparam int OUT_DEPTH   = 4;
	localparam int OUT_CREDITS = 2;

	// ============================================================
	// Operand and result constants
	// ============================================================
	localparam fp_value_t P_ZERO  = 64'h0000_0000_0000_0000;
	localparam fp_value_t N_ZERO  = 64'h8000_0000_0000_0000;
	localparam fp_value_t P_ONE   = 64'h3FF0_0000_0000_0000;
	localparam fp_value_t N_ONE   = 64'hBFF0_0000_0000_0000;
	localparam fp_value_t P_TWO   = 64'h4000_0000_0000_0000;
	localparam fp_value_t P_THREE = 64'h4008_0000_0000_0000;
	localparam fp_value_t N_THREE = 64'hC008_0000_0000_0000;
	localparam fp_value_t P_2_5   = 64'h4004_0000_0000_0000;
	localparam fp_value_t N_2_5   = 64'hC004_0000_0000_0000;
	localparam fp_value_t P_48    = 64'h4048_0000_0000_0000;
	localparam fp_value_t P_INF   = 64'h7FF0_0000_0000_0000;
	localparam fp_value_t N_INF   = 64'hFFF0_0000_0000_0000;
	localparam fp_value_t QNAN    = 64'h7FF8_0000_0000_0000;
	// Negative NaN with a payload bit, and the same NaN with the sign cleared
	localparam fp_value_t NNAN    = 64'hFFF8_0000_0000_0001;
	localparam fp_value_t PNAN    = 64'h7FF8_0000_0000_0001;

	// Integer scale operands with negative ones in two's complement
	localparam fp_value_t I_FOUR      = 64'd4;
	localparam fp_value_t I_TEN       = 64'd10;
	localparam fp_value_t I_BIG       = 64'd5000;
	localparam fp_value_t I_NEG_BIG   = 64'hFFFF_FFFF_FFFF_EC78;
	localparam fp_value_t I_NEG_THREE = 64'hFFFF_FFFF_FFFF_FFFD;

	localparam fp_value_t R_TRUE  = 64'd1;
	localparam fp_value_t R_FALSE = 64'd0;

	// Flag order is invalid, overflow, underflow
	localparam fpu_flags_t F_NONE = 3'b000;
	localparam fpu_flags_t F_INV  = 3'b100;
	localparam fpu_flags_t F_OVF  = 3'b010;
	localparam fpu_flags_t F_UNF  = 3'b001;

	logic     clk;
	logic     rst;
	logic     in_valid;
	fpu_req_t in_req;
	logic     in_credit;
	logic     out_valid;
	fpu_rsp_t out_rsp;
	logic     out_credit = 1'b0;

	// Test table with one entry per request
	string      vec_name[$];
	fpu_req_t   vec_req[$];
	fp_value_t  vec_result[$];
	fpu_flags_t vec_flags[$];

	integer seed;
	int     cycle = 0;
	int     sent = 0;
	int     credits_back = 0;
	int     rsp_count = 0;
	int     credits_seen = 0;
	int     credits_given = 0;
	int     credit_due[$];

	fpu_unit_top #(
		.IN_DEPTH    (IN_DEPTH),
		.OUT_DEPTH   (OUT_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) fpu_unit_top_inst (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_rsp    (out_rsp),
		.out_credit (out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ============================================================
	// Table construction
	// ============================================================
	task automatic add_vector(input string name, input fp_op_e op, input fp_value_t a,
			input fp_value_t b, input fp_value_t result, input fpu_flags_t flags);
		fpu_req_t req;
		req.op  = op;
		req.tag = '0;
		req.a   = a;
		req.b   = b;
		vec_name.push_back(name);
		vec_req.push_back(req);
		vec_result.push_back(result);
		vec_flags.push_back(flags);
	endtask

	task automatic build_table();
		// Sign manipulation touches bit 63 only
		add_vector("fabs_neg",    OP_FABS,    N_2_5,   P_ZERO,      P_2_5,   F_NONE);
		add_vector("fneg_pos",    OP_FNEG,    P_THREE, P_ZERO,      N_THREE, F_NONE);
		add_vector("fneg_zero",   OP_FNEG,    P_ZERO,  P_ZERO,      N_ZERO,  F_NONE);
		add_vector("fabs_nan",    OP_FABS,    NNAN,    P_ZERO,      PNAN,    F_NONE);
		add_vector("sgnj",        OP_SGNJ,    N_ONE,   P_THREE,     N_THREE, F_NONE);
		add_vector("sgnjn",       OP_SGNJN,   N_ONE,   P_THREE,     P_THREE, F_NONE);
		add_vector("sgnjx",       OP_SGNJX,   N_ONE,   N_2_5,       P_2_5,   F_NONE);
		add_vector("sgnjn_nan",   OP_SGNJN,   P_ZERO,  PNAN,        NNAN,    F_NONE);
		add_vector("sgnjx_zero",  OP_SGNJX,   N_ONE,   N_ZERO,      P_ZERO,  F_NONE);
		// Classification
		add_vector("fsign_pos",   OP_FSIGN,   P_THREE, P_ZERO,      P_ONE,   F_NONE);
		add_vector("fsign_neg",   OP_FSIGN,   N_2_5,   P_ZERO,      N_ONE,   F_NONE);
		add_vector("fsign_zero",  OP_FSIGN,   N_ZERO,  P_ZERO,      N_ZERO,  F_NONE);
		add_vector("fsign_nan",   OP_FSIGN,   QNAN,    P_ZERO,      QNAN,    F_NONE);
		add_vector("isnan_inf",   OP_ISNAN,   P_INF,   P_ZERO,      R_FALSE, F_NONE);
		add_vector("isnan_nan",   OP_ISNAN,   NNAN,    P_ZERO,      R_TRUE,  F_NONE);
		add_vector("isnan_norm",  OP_ISNAN,   P_TWO,   P_ZERO,      R_FALSE, F_NONE);
		add_vector("finite_inf",  OP_FINITE,  N_INF,   P_ZERO,      R_FALSE, F_NONE);
		add_vector("finite_nan",  OP_FINITE,  QNAN,    P_ZERO,      R_FALSE, F_NONE);
		add_vector("finite_norm", OP_FINITE,  N_2_5,   P_ZERO,      R_TRUE,  F_NONE);
		// Ordered comparison, signed zeros and NaN operands
		add_vector("fseq_zeros",  OP_FSEQ,    P_ZERO,  N_ZERO,      R_TRUE,  F_NONE);
		add_vector("fslt_mixed",  OP_FSLT,    N_2_5,   P_THREE,     R_TRUE,  F_NONE);
		add_vector("fsle_mixed",  OP_FSLE,    P_THREE, N_2_5,       R_FALSE, F_NONE);
		add_vector("fsne_nan",    OP_FSNE,    QNAN,    P_ONE,       R_TRUE,  F_NONE);
		add_vector("fseq_nan",    OP_FSEQ,    QNAN,    QNAN,        R_FALSE, F_NONE);
		add_vector("fslt_nan",    OP_FSLT,    QNAN,    P_ONE,       R_FALSE, F_INV);
		add_vector("fsle_nan",    OP_FSLE,    P_ONE,   NNAN,        R_FALSE, F_INV);
		// Scaleb
		// 3.0 * 2^4 is 48.0
		add_vector("scaleb_in",   OP_FSCALEB, P_THREE, I_FOUR,      P_48,    F_NONE);
		add_vector("scaleb_ovf",  OP_FSCALEB, N_ONE,   I_BIG,       N_INF,   F_OVF);
		add_vector("scaleb_unf",  OP_FSCALEB, P_TWO,   I_NEG_BIG,   P_ZERO,  F_UNF);
		add_vector("scaleb_inf",  OP_FSCALEB, N_INF,   I_TEN,       N_INF,   F_NONE);
		add_vector("scaleb_nan",  OP_FSCALEB, QNAN,    I_NEG_THREE, QNAN,    F_NONE);
	endtask

	// ============================================================
	// Checks
	// ============================================================
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_tag(input string name, input fpu_tag_t expected, input fpu_tag_t actual);
		if (actual !== expected) begin
			$display("ERR %s tag expected %h actual %h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "tag mismatch");
		end
	endtask

	task automatic check_result(input string name, input fp_value_t expected,
			input fp_value_t actual);
		if (actual !== expected) begin
			$display("ERR %s result expected %h actual %h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "result mismatch");
		end
	endtask

	task automatic check_flags(input string name, input fpu_flags_t expected,
			input fpu_flags_t actual);
		if (actual !== expected) begin
			$display("ERR %s flags expected %b actual %b", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "flags mismatch");
		end
	endtask

	// ============================================================
	// Upstream sender
	// ============================================================

	// Sends one request per cycle while a credit is held
	// The tag is the table index
	task automatic send_all();
		fpu_req_t req;
		int       i;
		i = 0;
		while (i < vec_req.size()) begin
			@(posedge clk);
			if (sent - credits_back < IN_DEPTH) begin
				req      = vec_req[i];
				req.tag  = fpu_tag_t'(i);
				in_valid <= 1'b1;
				in_req   <= req;
				sent++;
				i++;
			end else begin
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// ============================================================
	// Monitor samples on the falling edge where all DUT outputs are settled
	// ============================================================
	always @(negedge clk) begin
		int delay;
		if (!rst) begin
			if (in_credit)
				credits_back++;
			if (credits_back > sent)
				abort_run("in_credit pulsed with no request outstanding");
			if (out_valid) begin
				// A credit returned in this same cycle is not usable yet
				if (rsp_count >= OUT_CREDITS + credits_seen)
					abort_run("out_valid fired with no downstream credit left");
				if (rsp_count >= vec_req.size())
					abort_run("response arrived after every request was answered");
				check_tag(vec_name[rsp_count], fpu_tag_t'(rsp_count), out_rsp.tag);
				check_result(vec_name[rsp_count], vec_result[rsp_count], out_rsp.result);
				check_flags(vec_name[rsp_count], vec_flags[rsp_count], out_rsp.flags);
				// The freed slot goes back after 0 to 3 cycles
				delay = $unsigned($random(seed)) % 4;
				credit_due.push_back(cycle + 1 + delay);
				rsp_count++;
			end
			if (out_credit)
				credits_seen++;
		end
	end

	// Cycle counter, timeout and downstream credit return
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle > vec_req.size() * 20 + 50) begin
			$display("Responses stopped arriving, %0d of %0d received after %0d cycles",
				rsp_count, vec_req.size(), cycle);
			$display("TESTS FAILED");
			$fatal(1, "timeout");
		end
		if (credits_given < credit_due.size() && credit_due[credits_given] <= cycle) begin
			out_credit <= 1'b1;
			credits_given++;
		end else begin
			out_credit <= 1'b0;
		end
	end

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		seed     = 32'hd70b;
		rst      = 1'b1;
		in_valid = 1'b0;
		in_req   = '0;
		build_table();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		send_all();
		wait (rsp_count == vec_req.size());
		// Short drain so a stray extra response is still caught
		repeat (2 * FPU_LATENCY) @(posedge clk);
		// Every request popped from the queue must have handed its credit back
		if (credits_back != sent) begin
			abort_run("in_credit pulses do not match the number of requests sent");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

//--- hw/credit_fifo.sv
// Circular queue for any payload type
// Pulses a credit back to the producer for every entry it pops
module credit_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       push,
	input  payload_t                   din,
	input  logic                       pop,
	output payload_t                   dout,
	output logic                       not_empty,
	output logic [$clog2(DEPTH+1)-1:0] free,
	output logic                       credit
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_pop;

	// The producer only sends with a credit, so push never meets a full queue
	assign do_pop = pop && not_empty;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count alone
			if (push && !do_pop)
				count <= count + 1'b1;
			else if (!push && do_pop)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	assign dout      = mem[rd_ptr];
	assign not_empty = (count != '0);
	assign free      = CW'(DEPTH) - count;
	assign credit    = do_pop;

endmodule

//--- hw/fpu_compare.sv
// Ordered comparison of two binary64 values
// Plus and minus zero compare equal, a NaN operand makes the
// comparison unordered and FSLT and FSLE then raise invalid
module fpu_compare import fpu_pkg::*; (
	input  fp_value_t a,
	input  fp_value_t b,
	input  fp_op_e    op,
	output fp_value_t result,
	output logic      invalid
);

	logic unordered;
	logic both_zero;
	logic eq;
	logic lt;

	// A NaN has an all-ones exponent and a nonzero fraction
	assign unordered = ((&a[62:52]) && (a[51:0] != 52'd0)) ||
	                   ((&b[62:52]) && (b[51:0] != 52'd0));

	// Signed zeros differ only in bit 63
	assign both_zero = (a[62:0] == 63'd0) && (b[62:0] == 63'd0);
	assign eq        = both_zero || (a == b);

	// Sign-magnitude ordering
	always_comb begin
		if (both_zero)
			lt = 1'b0;
		else if (a[63] != b[63])
			lt = a[63];
		else if (a[63])
			lt = a[62:0] > b[62:0];
		else
			lt = a[62:0] < b[62:0];
	end

	always_comb begin
		result  = '0;
		invalid = 1'b0;
		case (op)
			OP_FSEQ: result[0] = ~unordered & eq;
			OP_FSNE: result[0] = unordered | ~eq;
			OP_FSLT: begin
				result[0] = ~unordered & lt;
				invalid   = unordered;
			end
			OP_FSLE: begin
				result[0] = ~unordered & (lt | eq);
				invalid   = unordered;
			end
			default: result = '0;
		endcase
	end

endmodule

//--- hw/fpu_exec_pipe.sv
// Execute pipe of the floating-point unit
// Gates issue against free response slots, feeds the operands to the
// sign, compare and scaleb units, and retimes every opcode to the
// common fixed latency before the result leaves on the retire port
module fpu_exec_pipe import fpu_pkg::*; #(
	parameter int OUT_DEPTH = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  fpu_req_t                       req,
	input  logic                           req_ready,
	input  logic [$clog2(OUT_DEPTH+1)-1:0] rsp_free,
	output logic                           issue,
	output logic                           ret_valid,
	output fpu_rsp_t                       ret_rsp
);

	localparam int FW = $clog2(OUT_DEPTH + 1);

	// Payload carried through the retiming stages
	typedef struct packed {
		fp_op_e   op;
		fpu_rsp_t rsp;
	} stage_t;

	fp_value_t  sign_result;
	fp_value_t  cmp_result;
	logic       cmp_invalid;
	fp_value_t  scl_result;
	fpu_flags_t scl_flags;

	stage_t     stage_in;
	fpu_rsp_t   final_rsp;
	stage_t     pipe_q [FPU_LATENCY-1];
	logic       valid_q [FPU_LATENCY];
	logic [FW-1:0] in_flight;

	// ============================================================
	// Issue gating
	// ============================================================

	// Every request in flight already owns one free response slot
	assign issue = req_ready && (in_flight < rsp_free);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			in_flight <= '0;
		else if (issue && !ret_valid)
			in_flight <= in_flight + 1'b1;
		else if (!issue && ret_valid)
			in_flight <= in_flight - 1'b1;
	end

	// ============================================================
	// Functional units
	// ============================================================
	fpu_sign_ops fpu_sign_ops_inst (
		.a      (req.a),
		.b      (req.b),
		.op     (req.op),
		.result (sign_result)
	);

	fpu_compare fpu_compare_inst (
		.a       (req.a),
		.b       (req.b),
		.op      (req.op),
		.result  (cmp_result),
		.invalid (cmp_invalid)
	);

	// Scaleb only loads on its own opcode
	fpu_scaleb fpu_scaleb_inst (
		.clk    (clk),
		.rst    (rst),
		.en     (issue && (req.op == OP_FSCALEB)),
		.a      (req.a),
		.b      (req.b),
		.result (scl_result),
		.flags  (scl_flags)
	);

	// Pick the one-cycle result that enters the first stage
	always_comb begin
		stage_in.op        = req.op;
		stage_in.rsp.tag   = req.tag;
		stage_in.rsp.flags = '0;
		case (req.op)
			OP_FSEQ, OP_FSNE, OP_FSLT, OP_FSLE: begin
				stage_in.rsp.result        = cmp_result;
				stage_in.rsp.flags.invalid = cmp_invalid;
			end
			default: stage_in.rsp.result = sign_result;
		endcase
	end

	// Scaleb joins at the final stage, two cycles after issue
	always_comb begin
		final_rsp = pipe_q[FPU_LATENCY-2].rsp;
		if (pipe_q[FPU_LATENCY-2].op == OP_FSCALEB) begin
			final_rsp.result = scl_result;
			final_rsp.flags  = scl_flags;
		end
	end

	// ============================================================
	// Retiming shift register
	// ============================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < FPU_LATENCY; i++)
				valid_q[i] <= 1'b0;
		end else begin
			valid_q[0] <= issue;
			for (int i = 1; i < FPU_LATENCY; i++)
				valid_q[i] <= valid_q[i-1];
		end
	end

	always_ff @(posedge clk) begin
		pipe_q[0] <= stage_in;
		for (int i = 1; i < FPU_LATENCY - 1; i++)
			pipe_q[i] <= pipe_q[i-1];
		ret_rsp <= final_rsp;
	end

	assign ret_valid = valid_q[FPU_LATENCY-1];

endmodule

//--- hw/fpu_pkg.sv
// Shared types for the scalar binary64 execute unit
// Holds the operand word, opcode set, flag bundle, request and response
// records, and the fixed pipeline depth used by the execute pipe
package fpu_pkg;

	// ============================================================
	// Operand and tag types
	// ============================================================

	// One 64-bit word, either a binary64 value or a plain integer
	typedef logic [63:0] fp_value_t;

	// Tag lets the consumer match a response to its request
	typedef logic [3:0] fpu_tag_t;

	// ============================================================
	// Opcodes
	// ============================================================

	// Sign manipulation and classification come first, then the
	// ordered comparisons, then scaleb
	typedef enum logic [3:0] {
		OP_FABS    = 4'd0,
		OP_FNEG    = 4'd1,
		OP_SGNJ    = 4'd2,
		OP_SGNJN   = 4'd3,
		OP_SGNJX   = 4'd4,
		OP_FSIGN   = 4'd5,
		OP_ISNAN   = 4'd6,
		OP_FINITE  = 4'd7,
		OP_FSEQ    = 4'd8,
		OP_FSNE    = 4'd9,
		OP_FSLT    = 4'd10,
		OP_FSLE    = 4'd11,
		OP_FSCALEB = 4'd12
	} fp_op_e;

	// ============================================================
	// Flags, requests and responses
	// ============================================================

	// Invalid comes from an unordered FSLT or FSLE
	// Overflow and underflow come from scaleb saturation
	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
	} fpu_flags_t;

	// Request as it arrives from the issue stage
	typedef struct packed {
		fp_op_e    op;
		fpu_tag_t  tag;
		fp_value_t a;
		fp_value_t b;
	} fpu_req_t;

	// Response as it leaves on the result bus
	typedef struct packed {
		fpu_tag_t   tag;
		fp_value_t  result;
		fpu_flags_t flags;
	} fpu_rsp_t;

	// Every opcode retires this many cycles after issue
	localparam int FPU_LATENCY = 3;

endpackage

//--- hw/fpu_rsp_port.sv
// Response side of the floating-point unit
// Buffers retired results and sends them while the downstream
// consumer has credits left
module fpu_rsp_port import fpu_pkg::*; #(
	parameter int OUT_DEPTH   = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           ret_valid,
	input  fpu_rsp_t                       ret_rsp,
	input  logic                           out_credit,
	output logic [$clog2(OUT_DEPTH+1)-1:0] rsp_free,
	output logic                           out_valid,
	output fpu_rsp_t                       out_rsp
);

	localparam int CRW = $clog2(OUT_CREDITS + 1);

	logic           rsp_avail;
	logic [CRW-1:0] credits;

	credit_fifo #(
		.payload_t (fpu_rsp_t),
		.DEPTH     (OUT_DEPTH)
	) rsp_fifo_inst (
		.clk       (clk),
		.rst       (rst),
		.push      (ret_valid),
		.din       (ret_rsp),
		.pop       (out_valid),
		.dout      (out_rsp),
		.not_empty (rsp_avail),
		.free      (rsp_free),
		.credit    ()
	);

	// Send and pop together whenever the consumer has room
	assign out_valid = rsp_avail && (credits != '0);

	// Downstream credit counter, a send and a return in one cycle cancel
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			credits <= CRW'(OUT_CREDITS);
		else if (out_valid && !out_credit)
			credits <= credits - 1'b1;
		else if (!out_valid && out_credit)
			credits <= credits + 1'b1;
	end

endmodule

//--- hw/fpu_scaleb.sv
// Binary64 scale by a power of two, a * 2^b with b a signed integer
// Two register stages, subnormal inputs flush to a signed zero and
// results outside the normal range saturate with a flag
module fpu_scaleb import fpu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       en,
	input  fp_value_t  a,
	input  fp_value_t  b,
	output fp_value_t  result,
	output fpu_flags_t flags
);

	logic signed [63:0] b_int;
	logic signed [13:0] b_clamp;
	logic signed [13:0] exp_sum;

	// Stage one registers
	logic               s1_valid;
	logic               s1_sign;
	logic [51:0]        s1_frac;
	logic               s1_zero;
	logic               s1_special;
	logic signed [13:0] s1_sum;

	// Beyond +-4096 the answer is saturated anyway
	assign b_int = $signed(b);
	always_comb begin
		if (b_int > 64'sd4096)
			b_clamp = 14'sd4096;
		else if (b_int < -64'sd4096)
			b_clamp = -14'sd4096;
		else
			b_clamp = b_int[13:0];
	end

	// Largest sum is 2047 + 4096, which fits in 14 signed bits
	assign exp_sum = $signed({3'b000, a[62:52]}) + b_clamp;

	// ============================================================
	// Stage one: classify a and form the exponent sum
	// ============================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= en;
	end

	always_ff @(posedge clk) begin
		if (en) begin
			s1_sign    <= a[63];
			s1_frac    <= a[51:0];
			// Zero exponent covers both zero and subnormal
			s1_zero    <= (a[62:52] == 11'd0);
			s1_special <= &a[62:52];
			s1_sum     <= exp_sum;
		end
	end

	// ============================================================
	// Stage two: pass-through, saturation or exponent replacement
	// ============================================================
	always_ff @(posedge clk) begin
		if (s1_valid) begin
			flags <= '0;
			if (s1_special) begin
				// Infinity and NaN keep their payload
				result <= {s1_sign, 11'h7ff, s1_frac};
			end else if (s1_zero) begin
				result <= {s1_sign, 63'd0};
			end else if (s1_sum >= 14'sd2047) begin
				result         <= {s1_sign, 11'h7ff, 52'd0};
				flags.overflow <= 1'b1;
			end else if (s1_sum <= 14'sd0) begin
				result          <= {s1_sign, 63'd0};
				flags.underflow <= 1'b1;
			end else begin
				result <= {s1_sign, s1_sum[10:0], s1_frac};
			end
		end
	end

endmodule

//--- hw/fpu_sign_ops.sv
// Sign manipulation and classification for binary64 operands
// Purely combinational, results are registered by the execute pipe
module fpu_sign_ops import fpu_pkg::*; (
	input  fp_value_t a,
	input  fp_value_t b,
	input  fp_op_e    op,
	output fp_value_t result
);

	logic [10:0] a_exp;
	logic [51:0] a_frac;
	logic        a_exp_ones;
	logic        a_zero;
	logic        a_nan;

	// Field split of operand a
	assign a_exp      = a[62:52];
	assign a_frac     = a[51:0];
	assign a_exp_ones = &a_exp;
	assign a_zero     = (a_exp == 11'd0) && (a_frac == 52'd0);
	assign a_nan      = a_exp_ones && (a_frac != 52'd0);

	always_comb begin
		result = '0;
		case (op)
			OP_FABS:   result = {1'b0, a[62:0]};
			OP_FNEG:   result = {~a[63], a[62:0]};
			// Sign injection keeps the magnitude of b
			OP_SGNJ:   result = {a[63], b[62:0]};
			OP_SGNJN:  result = {~a[63], b[62:0]};
			OP_SGNJX:  result = {a[63] ^ b[63], b[62:0]};
			OP_FSIGN: begin
				// Zeros and NaNs come back unchanged, anything else is +-1.0
				if (a_zero || a_nan)
					result = a;
				else
					result = {a[63], 11'h3ff, 52'd0};
			end
			OP_ISNAN:  result = {63'd0, a_nan};
			// Infinity and NaN both have an all-ones exponent
			OP_FINITE: result = {63'd0, ~a_exp_ones};
			default:   result = '0;
		endcase
	end

endmodule

//--- hw/fpu_unit_top.sv
// Top level of the scalar floating-point execute unit
// Request queue, execute pipe and response port, with credit flow
// control on both the request and the response side
module fpu_unit_top import fpu_pkg::*; #(
	parameter int IN_DEPTH    = 4,
	parameter int OUT_DEPTH   = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	input  fpu_req_t in_req,
	output logic     in_credit,
	output logic     out_valid,
	output fpu_rsp_t out_rsp,
	input  logic     out_credit
);

	fpu_req_t                       head_req;
	logic                           head_ready;
	logic                           issue;
	logic [$clog2(OUT_DEPTH+1)-1:0] rsp_free;
	logic                           ret_valid;
	fpu_rsp_t                       ret_rsp;

	// Each pop hands one credit back to the issue stage
	credit_fifo #(
		.payload_t (fpu_req_t),
		.DEPTH     (IN_DEPTH)
	) req_fifo_inst (
		.clk       (clk),
		.rst       (rst),
		.push      (in_valid),
		.din       (in_req),
		.pop       (issue),
		.dout      (head_req),
		.not_empty (head_ready),
		.free      (),
		.credit    (in_credit)
	);

	fpu_exec_pipe #(
		.OUT_DEPTH (OUT_DEPTH)
	) fpu_exec_pipe_inst (
		.clk       (clk),
		.rst       (rst),
		.req       (head_req),
		.req_ready (head_ready),
		.rsp_free  (rsp_free),
		.issue     (issue),
		.ret_valid (ret_valid),
		.ret_rsp   (ret_rsp)
	);

	fpu_rsp_port #(
		.OUT_DEPTH   (OUT_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) fpu_rsp_port_inst (
		.clk        (clk),
		.rst        (rst),
		.ret_valid  (ret_valid),
		.ret_rsp    (ret_rsp),
		.out_credit (out_credit),
		.rsp_free   (rsp_free),
		.out_valid  (out_valid),
		.out_rsp    (out_rsp)
	);

endmodule

//--- vlog.f
hw/fpu_pkg.sv
hw/credit_fifo.sv
hw/fpu_sign_ops.sv
hw/fpu_compare.sv
hw/fpu_scaleb.sv
hw/fpu_exec_pipe.sv
hw/fpu_rsp_port.sv
hw/fpu_unit_top.sv
dv/fpu_unit_tb.sv
